/* alu_exec.f */
+incdir+rtl
rtl/cpu_types_pkg.sv
rtl/exec_pkg.sv
rtl/alu_if.sv
rtl/alu_dispatch.sv
rtl/alu_lane.sv
rtl/alu_writeback.sv
rtl/alu_exec.sv
sim/alu_exec_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile the execute cluster and its testbench with Verilator, run, and judge the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module alu_exec_tb -f alu_exec.f -o alu_exec_sim \
  || { echo "Build failed"; exit 1; }

out=$(./obj_dir/alu_exec_sim)
echo "$out"

echo "$out" | grep -qx "No errors" && echo "PASS" || { echo "FAIL"; exit 1; }

/* sim/alu_exec_tb.sv */
// Testbench alu_exec_tb: reference model, xorshift stimulus, directed tests, result monitor, watchdog
`timescale 1ns/10ps
`include "alu_exec_defs.svh"

module alu_exec_tb;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 10;
  localparam int OUT_SEEN     = 3;   // Result seen at the 3rd rising edge after its input edge
  localparam int ILL_SEEN     = 1;   // Illegal pulse seen 1 edge after its input edge
  localparam int N_DIRECTED   = 15;
  localparam int DIR_GAP      = 4;
  localparam int N_STREAM     = 40;
  localparam int N_MIX        = 24;
  localparam int N_SPACED     = 30;
  localparam int MAX_GAP      = 3;
  // All test cycles, a drain per test, then margin
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 6 + N_DIRECTED * (DIR_GAP + 1) + N_STREAM
                                   + N_MIX + N_SPACED * (MAX_GAP + 1) + 5 * 8 + 50;

  typedef logic [`WORD_W-1:0]  data_t;
  typedef logic [`FUNCT_W-1:0] code_t;

  // R-type funct codes
  localparam code_t F_SLL  = 6'h00;
  localparam code_t F_SRL  = 6'h02;
  localparam code_t F_ADD  = 6'h20;
  localparam code_t F_ADDU = 6'h21;
  localparam code_t F_SUB  = 6'h22;
  localparam code_t F_SUBU = 6'h23;
  localparam code_t F_AND  = 6'h24;
  localparam code_t F_OR   = 6'h25;
  localparam code_t F_XOR  = 6'h26;
  localparam code_t F_NOR  = 6'h27;
  localparam code_t F_SLT  = 6'h2A;
  localparam code_t F_SLTU = 6'h2B;
  localparam code_t LEGAL [12] = '{F_SLL, F_SRL, F_ADD, F_ADDU, F_SUB, F_SUBU,
                                   F_AND, F_OR, F_XOR, F_NOR, F_SLT, F_SLTU};

  // Expected result with the code it came from
  typedef struct packed {
    code_t funct;
    data_t res;
    logic  neg;
    logic  zero;
    logic  over;
  } exp_t;

  logic  CLK = 1'b0;
  logic  rst;
  logic  in_valid;
  code_t funct;
  data_t port_a;
  data_t port_b;
  logic  out_valid;
  logic  illegal;
  data_t port_o;
  logic  neg;
  logic  zero;
  logic  over;

  exp_t  exp_q [$];      // Pending results, input order
  int    edge_q [$];     // Input edge of each pending result
  int    ill_q [$];      // Input edges of illegal codes
  int    edge_cnt     = 0;
  int    checked      = 0;
  int    value_errors = 0;
  int    other_errors = 0;
  data_t rng          = 32'd68;

  alu_exec i_alu_exec (
    .CLK       (CLK),
    .rst       (rst),
    .in_valid  (in_valid),
    .funct     (funct),
    .port_a    (port_a),
    .port_b    (port_b),
    .out_valid (out_valid),
    .illegal   (illegal),
    .port_o    (port_o),
    .neg       (neg),
    .zero      (zero),
    .over      (over)
  );

  initial begin
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  function automatic data_t rand32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic is_legal(input code_t f);
    foreach (LEGAL[i])
      if (LEGAL[i] == f) return 1'b1;
    return 1'b0;
  endfunction

  function automatic code_t pick_illegal();
    data_t r;
    r = rand32();
    while (is_legal(r[`FUNCT_W-1:0])) r = rand32();  // Redraw until unknown
    return r[`FUNCT_W-1:0];
  endfunction

  // Lane behavior from the ISA rules
  function automatic exp_t model(input code_t f, input data_t a, input data_t b);
    exp_t             r;
    logic [`WORD_W:0] wide;  // Sign-extended add or subtract
    r       = '0;
    r.funct = f;
    case (f)
      F_SLL:  r.res = b << a[`SHAMT_W-1:0];
      F_SRL:  r.res = b >> a[`SHAMT_W-1:0];
      F_ADD, F_ADDU, F_SUB, F_SUBU: begin
        if (f == F_SUB || f == F_SUBU)
          wide = {a[`WORD_W-1], a} - {b[`WORD_W-1], b};
        else
          wide = {a[`WORD_W-1], a} + {b[`WORD_W-1], b};
        r.res  = wide[`WORD_W-1:0];
        r.neg  = wide[`WORD_W-1];
        r.zero = (r.res == '0);
        r.over = wide[`WORD_W] != wide[`WORD_W-1];  // Extra sign bit disagrees
      end
      F_AND:  r.res = a & b;
      F_OR:   r.res = a | b;
      F_XOR:  r.res = a ^ b;
      F_NOR:  r.res = ~(a | b);
      F_SLT:  r.res[0] = $signed(a) < $signed(b);
      F_SLTU: r.res[0] = a < b;
      default: ;
    endcase
    return r;
  endfunction

  task automatic drive_op(input code_t f, input data_t a, input data_t b);
    @(negedge CLK);
    in_valid = 1'b1;
    funct    = f;
    port_a   = a;
    port_b   = b;
    if (is_legal(f)) begin
      exp_q.push_back(model(f, a, b));
      edge_q.push_back(edge_cnt + 1);  // Sampled at the coming rising edge
    end else begin
      ill_q.push_back(edge_cnt + 1);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge CLK);
      in_valid = 1'b0;
    end
  endtask

  task automatic wait_drain();
    idle(1);
    while (exp_q.size() != 0 || ill_q.size() != 0) @(negedge CLK);
    idle(2);  // Room for stray strobes
  endtask

  task automatic print_counts();
    $display("Summary: %0d results checked, %0d value errors, %0d other errors",
             checked, value_errors, other_errors);
  endtask

  // Rising-edge monitor, reads registered outputs before they update
  initial begin : monitor
    exp_t e;
    int   e_edge;
    forever begin
      @(posedge CLK);
      edge_cnt = edge_cnt + 1;
      if (out_valid === 1'b1) begin
        assert (exp_q.size() != 0) else begin
          other_errors++;
          $display("A result appeared at %0t with no operation outstanding", $time);
        end
        if (exp_q.size() != 0) begin
          e      = exp_q.pop_front();
          e_edge = edge_q.pop_front();
          checked++;
          assert (e_edge + OUT_SEEN == edge_cnt) else begin
            other_errors++;
            $display("Result of the input at edge %0d came out at edge %0d instead of %0d",
                     e_edge, edge_cnt, e_edge + OUT_SEEN);
          end
          assert (port_o === e.res) else begin
            value_errors++;
            $display("error %0t: port_o %08h, expected %08h (funct %02h)",
                     $time, port_o, e.res, e.funct);
          end
          assert ({neg, zero, over} === {e.neg, e.zero, e.over}) else begin
            value_errors++;
            $display("error %0t: flags nzv %b%b%b, expected %b%b%b (funct %02h)",
                     $time, neg, zero, over, e.neg, e.zero, e.over, e.funct);
          end
        end
      end
      assert (edge_q.size() == 0 || edge_q[0] + OUT_SEEN >= edge_cnt) else begin
        other_errors++;
        $display("The result of the input at edge %0d never came out", edge_q[0]);
        void'(exp_q.pop_front());
        void'(edge_q.pop_front());
      end
      if (illegal === 1'b1) begin
        assert (ill_q.size() != 0 && ill_q[0] + ILL_SEEN == edge_cnt) else begin
          other_errors++;
          $display("An illegal pulse at %0t matches no unknown funct code", $time);
        end
        if (ill_q.size() != 0 && ill_q[0] + ILL_SEEN == edge_cnt) void'(ill_q.pop_front());
      end
      assert (ill_q.size() == 0 || ill_q[0] + ILL_SEEN >= edge_cnt) else begin
        other_errors++;
        $display("The unknown funct code at edge %0d raised no illegal pulse", ill_q[0]);
        void'(ill_q.pop_front());
      end
    end
  end

  // Outputs quiet in and right after reset
  task automatic test_reset();
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(negedge CLK);
      if (i > 0)
        assert (out_valid === 1'b0 && illegal === 1'b0) else begin
          value_errors++;
          $display("error %0t: out_valid or illegal high during reset", $time);
        end
    end
    rst = 1'b0;
    repeat (6) begin
      @(negedge CLK);
      assert (out_valid === 1'b0 && illegal === 1'b0) else begin
        value_errors++;
        $display("error %0t: out_valid or illegal high after reset", $time);
      end
    end
  endtask

  task automatic directed_op(input code_t f, input data_t a, input data_t b);
    drive_op(f, a, b);
    idle(DIR_GAP);
  endtask

  // Edge values, one or more per code
  task automatic test_directed();
    directed_op(F_ADD,  32'h7FFF_FFFF, 32'h0000_0001);  // Overflow into negative
    directed_op(F_ADD,  32'h0000_0000, 32'h0000_0000);  // Zero
    directed_op(F_ADDU, 32'h7FFF_FFFF, 32'h0000_0001);
    directed_op(F_SUB,  32'h8000_0000, 32'h0000_0001);  // Negative minus positive
    directed_op(F_SUB,  32'h7FFF_FFFF, 32'hFFFF_FFFF);  // Positive minus negative
    directed_op(F_SUBU, 32'h0000_0005, 32'h0000_0005);
    directed_op(F_AND,  32'hF0F0_1234, 32'h0FF0_FFFF);
    directed_op(F_OR,   32'hF000_0001, 32'h0000_8000);
    directed_op(F_XOR,  32'hAAAA_5555, 32'hFFFF_0000);
    directed_op(F_NOR,  32'h0000_0000, 32'h0000_0000);
    directed_op(F_SLT,  32'hFFFF_FFFF, 32'h0000_0001);  // -1 < 1
    directed_op(F_SLT,  32'h8000_0000, 32'hFFFF_FFFF);  // Both negative
    directed_op(F_SLTU, 32'hFFFF_FFFF, 32'h0000_0001);  // Large unsigned
    directed_op(F_SLL,  32'h0000_0004, 32'h8765_4321);
    directed_op(F_SRL,  32'h0000_0004, 32'h8765_4321);
    wait_drain();
  endtask

  // One op per cycle, every lane reused
  task automatic test_stream();
    for (int i = 0; i < N_STREAM; i++)
      drive_op(LEGAL[int'(rand32() % 32'd12)], rand32(), rand32());
    wait_drain();
  endtask

  // Every third op unknown
  task automatic test_illegal();
    for (int i = 0; i < N_MIX; i++) begin
      if (i % 3 == 1)
        drive_op(pick_illegal(), rand32(), rand32());
      else
        drive_op(LEGAL[int'(rand32() % 32'd12)], rand32(), rand32());
    end
    wait_drain();
  endtask

  // Gaps of 0 to MAX_GAP idle cycles
  task automatic test_spacing();
    for (int i = 0; i < N_SPACED; i++) begin
      drive_op(LEGAL[int'(rand32() % 32'd12)], rand32(), rand32());
      idle(int'(rand32() % 32'(MAX_GAP + 1)));
    end
    wait_drain();
  endtask

  initial begin
    rst      = 1'b1;
    in_valid = 1'b0;
    funct    = '0;
    port_a   = '0;
    port_b   = '0;
    test_reset();
    test_directed();
    test_stream();
    test_illegal();
    test_spacing();
    print_counts();
    if (value_errors + other_errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  // Hang guard
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("The run hung: the tests did not finish before the watchdog time ran out");
    print_counts();
    $display("Errors found");
    $finish;
  end

endmodule

/* rtl/alu_exec.sv */
// Module alu_exec: execute cluster top with dispatcher, lane array and writeback
`timescale 1ns/10ps
`include "alu_exec_defs.svh"

module alu_exec
  import cpu_types_pkg::*;
  (
  input  logic                CLK,
  input  logic                rst,
  input  logic                in_valid,
  input  logic [`FUNCT_W-1:0] funct,
  input  logic [`WORD_W-1:0]  port_a,
  input  logic [`WORD_W-1:0]  port_b,
  output logic                out_valid,
  output logic                illegal,
  output logic [`WORD_W-1:0]  port_o,
  output logic                neg,
  output logic                zero,
  output logic                over
);

  // One bus per lane
  alu_if lane_bus [`ALU_LANES] ();

  // Decode and issue, illegal codes flagged here
  alu_dispatch i_dispatch (
    .CLK      (CLK),
    .rst      (rst),
    .in_valid (in_valid),
    .funct    (funct_t'(funct)),  // Raw field, unknown codes caught by decode
    .port_a   (port_a),
    .port_b   (port_b),
    .illegal  (illegal),
    .lanes    (lane_bus)
  );

  // Identical fixed-latency lanes
  for (genvar g = 0; g < `ALU_LANES; g++) begin : g_lane
    alu_lane i_lane (
      .CLK (CLK),
      .rst (rst),
      .bus (lane_bus[g])
    );
  end

  // Merge back into one ordered stream
  alu_writeback i_writeback (
    .CLK       (CLK),
    .rst       (rst),
    .lanes     (lane_bus),
    .out_valid (out_valid),
    .port_o    (port_o),
    .neg       (neg),
    .zero      (zero),
    .over      (over)
  );

endmodule

/* rtl/alu_writeback.sv */
// Module alu_writeback: drains the lanes in issue order into one result stream
`timescale 1ns/10ps
`include "alu_exec_defs.svh"

module alu_writeback
  import cpu_types_pkg::*, exec_pkg::*;
  (
  input  logic   CLK,
  input  logic   rst,
  alu_if.collect lanes [`ALU_LANES],
  output logic   out_valid,
  output word_t  port_o,
  output logic   neg,
  output logic   zero,
  output logic   over
);

  lane_sel_t              ptr;                   // Lane whose result is due next
  logic [`ALU_LANES-1:0]  done_v;                // Done strobes of all lanes
  logic [`ALU_LANES-1:0]  due_mask;              // One-hot of ptr
  word_t                  res_v [`ALU_LANES];
  alu_flags_t             flg_v [`ALU_LANES];

  // Flatten the interface array so ptr can index it
  for (genvar g = 0; g < `ALU_LANES; g++) begin : g_gather
    assign done_v[g]   = lanes[g].done;
    assign res_v[g]    = lanes[g].port_o;
    assign flg_v[g]    = lanes[g].flags;
    assign due_mask[g] = (ptr == lane_sel_t'(g));
  end

  // Same rotation as the dispatcher, one stage later
  always_ff @(posedge CLK) begin
    if (rst) begin
      ptr       <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= done_v[ptr];
      if (done_v[ptr]) begin
        if (ptr == lane_sel_t'(`ALU_LANES - 1))
          ptr <= '0;
        else
          ptr <= ptr + 1'b1;
      end
    end
  end

  // Output payload
  always_ff @(posedge CLK) begin
    if (done_v[ptr]) begin
      port_o <= res_v[ptr];
      neg    <= flg_v[ptr].neg;
      zero   <= flg_v[ptr].zero;
      over   <= flg_v[ptr].over;
    end
  end

  // Dispatch and writeback rotations stay in step
  a_in_order: assert property (
    @(posedge CLK) disable iff (rst) (done_v & ~due_mask) == '0
  );

endmodule

/* rtl/alu_lane.sv */
// Module alu_lane: one registered ALU with result and N/Z/V flags
`timescale 1ns/10ps
`include "alu_exec_defs.svh"

module alu_lane
  import cpu_types_pkg::*, exec_pkg::*;
  (
  input  logic CLK,
  input  logic rst,
  alu_if.lane  bus
);

  localparam int MSB = `WORD_W - 1;

  word_t                res;       // Combinational result
  alu_flags_t           flg;       // Combinational flags
  logic [`SHAMT_W-1:0]  shamt;     // Shift distance
  logic                 lt_s;      // Signed a < b
  logic                 lt_u;      // Unsigned a < b
  word_t                sum;
  word_t                diff;

  assign shamt = bus.port_a[`SHAMT_W-1:0];
  assign lt_s  = $signed(bus.port_a) < $signed(bus.port_b);
  assign lt_u  = bus.port_a < bus.port_b;
  assign sum   = bus.port_a + bus.port_b;
  assign diff  = bus.port_a - bus.port_b;

  always_comb begin
    res = '0;
    flg = '0;  // Flags stay clear except for ADD and SUB
    case (bus.alu_op)
      ALU_SLL:  res = bus.port_b << shamt;  // port_b is the shifted value
      ALU_SRL:  res = bus.port_b >> shamt;
      ALU_ADD: begin
        res      = sum;
        flg.zero = (sum == '0);
        flg.neg  = sum[MSB];
        // Same-sign operands, result sign flipped
        flg.over = (bus.port_a[MSB] == bus.port_b[MSB]) &&
                   (sum[MSB] != bus.port_a[MSB]);
      end
      ALU_SUB: begin
        res      = diff;
        flg.zero = (diff == '0);
        flg.neg  = diff[MSB];
        // Opposite-sign operands, result sign away from port_a
        flg.over = (bus.port_a[MSB] != bus.port_b[MSB]) &&
                   (diff[MSB] != bus.port_a[MSB]);
      end
      ALU_AND:  res = bus.port_a & bus.port_b;
      ALU_OR:   res = bus.port_a | bus.port_b;
      ALU_XOR:  res = bus.port_a ^ bus.port_b;
      ALU_NOR:  res = ~(bus.port_a | bus.port_b);
      ALU_SLT:  res = {{(`WORD_W-1){1'b0}}, lt_s};   // 1 or 0
      ALU_SLTU: res = {{(`WORD_W-1){1'b0}}, lt_u};
      default:  res = '0;
    endcase
  end

  // Done strobe follows issue by one edge
  always_ff @(posedge CLK) begin
    if (rst)
      bus.done <= 1'b0;
    else
      bus.done <= bus.issue;
  end

  // Result registers, loaded only on issue
  always_ff @(posedge CLK) begin
    if (bus.issue) begin
      bus.port_o <= res;
      bus.flags  <= flg;
    end
  end

  // A result only ever comes from an issued op
  a_done_after_issue: assert property (
    @(posedge CLK) disable iff (rst) bus.done |-> $past(bus.issue)
  );

endmodule

/* rtl/alu_dispatch.sv */
// Module alu_dispatch: funct decode, illegal detect, round-robin issue to the lanes
`timescale 1ns/10ps
`include "alu_exec_defs.svh"

module alu_dispatch
  import cpu_types_pkg::*, exec_pkg::*;
  (
  input  logic    CLK,
  input  logic    rst,
  input  logic    in_valid,
  input  funct_t  funct,
  input  word_t   port_a,
  input  word_t   port_b,
  output logic    illegal,
  alu_if.dispatch lanes [`ALU_LANES]
);

  aluop_t                 dec_op;     // Decoded opcode
  logic                   dec_legal;  // Funct is one we execute
  logic                   take;       // Legal op this cycle
  lane_sel_t              ptr;        // Next lane to load
  logic [`ALU_LANES-1:0]  issue_vec;  // Issue strobes gathered for the check

  // Funct to ALU opcode
  always_comb begin
    dec_op    = ALU_ADD;
    dec_legal = 1'b1;
    case (funct)
      SLL:        dec_op = ALU_SLL;
      SRL:        dec_op = ALU_SRL;
      ADD, ADDU:  dec_op = ALU_ADD;  // Unsigned forms share the adder
      SUB, SUBU:  dec_op = ALU_SUB;
      AND:        dec_op = ALU_AND;
      OR:         dec_op = ALU_OR;
      XOR:        dec_op = ALU_XOR;
      NOR:        dec_op = ALU_NOR;
      SLT:        dec_op = ALU_SLT;
      SLTU:       dec_op = ALU_SLTU;
      default:    dec_legal = 1'b0;  // Unknown code, not issued
    endcase
  end

  assign take = in_valid & dec_legal;

  // Illegal pulse replaces the issue, same latency
  always_ff @(posedge CLK) begin
    if (rst) begin
      illegal <= 1'b0;
    end else begin
      illegal <= in_valid & ~dec_legal;
    end
  end

  // Rotate over the lanes, wrap at the last one
  always_ff @(posedge CLK) begin
    if (rst) begin
      ptr <= '0;
    end else if (take) begin
      if (ptr == lane_sel_t'(`ALU_LANES - 1))
        ptr <= '0;
      else
        ptr <= ptr + 1'b1;
    end
  end

  // One issue register set per lane
  for (genvar g = 0; g < `ALU_LANES; g++) begin : g_issue
    logic sel;
    assign sel = take & (ptr == lane_sel_t'(g));

    always_ff @(posedge CLK) begin
      if (rst)
        lanes[g].issue <= 1'b0;
      else
        lanes[g].issue <= sel;
    end

    // Payload held until the lane comes round again
    always_ff @(posedge CLK) begin
      if (sel) begin
        lanes[g].alu_op <= dec_op;
        lanes[g].port_a <= port_a;
        lanes[g].port_b <= port_b;
      end
    end

    assign issue_vec[g] = lanes[g].issue;
  end

  // Never two lanes loaded at once
  a_one_issue: assert property (@(posedge CLK) disable iff (rst) $onehot0(issue_vec));

endmodule

/* rtl/alu_if.sv */
// Interface alu_if: issue side and result side of one ALU lane
`timescale 1ns/10ps

interface alu_if
  import cpu_types_pkg::*, exec_pkg::*;
  ();

  // Issue side, single-cycle strobe with payload
  logic       issue;
  aluop_t     alu_op;
  word_t      port_a;
  word_t      port_b;

  // Result side, done one cycle after issue
  logic       done;
  word_t      port_o;
  alu_flags_t flags;

  // Dispatcher loads the lane
  modport dispatch (
    output issue, alu_op, port_a, port_b
  );

  // Lane consumes an op, returns the result
  modport lane (
    input  issue, alu_op, port_a, port_b,
    output done, port_o, flags
  );

  // Writeback picks results up
  modport collect (
    input done, port_o, flags
  );

endinterface

/* rtl/exec_pkg.sv */
// Execute-cluster types: lane index and result flag bundle
`include "alu_exec_defs.svh"

package exec_pkg;

  // Round-robin pointer into the lane array
  localparam int LANE_SEL_W = $clog2(`ALU_LANES);

  typedef logic [LANE_SEL_W-1:0] lane_sel_t;

  // Status bits that ride along with every result
  // Only ADD and SUB set them
  typedef struct packed {
    logic neg;   // Result sign
    logic zero;  // Result all zeros
    logic over;  // Signed overflow, reported only
  } alu_flags_t;

endpackage

/* rtl/cpu_types_pkg.sv */
// ISA types: data word, R-type funct codes and ALU opcodes
`include "alu_exec_defs.svh"

package cpu_types_pkg;

  // One register-sized value
  typedef logic [`WORD_W-1:0] word_t;

  // R-type funct field, only the codes this cluster executes
  typedef enum logic [`FUNCT_W-1:0] {
    SLL  = 6'h00,  // Shift left logical
    SRL  = 6'h02,  // Shift right logical
    ADD  = 6'h20,
    ADDU = 6'h21,  // Same datapath as ADD
    SUB  = 6'h22,
    SUBU = 6'h23,  // Same datapath as SUB
    AND  = 6'h24,
    OR   = 6'h25,
    XOR  = 6'h26,
    NOR  = 6'h27,
    SLT  = 6'h2A,  // Signed set-less-than
    SLTU = 6'h2B   // Unsigned set-less-than
  } funct_t;

  // Operations the lane datapath knows
  typedef enum logic [3:0] {
    ALU_SLL,
    ALU_SRL,
    ALU_ADD,   // Flags valid
    ALU_SUB,   // Flags valid
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOR,
    ALU_SLT,
    ALU_SLTU
  } aluop_t;

endpackage

/* rtl/alu_exec_defs.svh */
// Width and lane-count macros for the execute cluster
`ifndef ALU_EXEC_DEFS_SVH
`define ALU_EXEC_DEFS_SVH

// Data path word
`define WORD_W 32

// Shift amount comes from the low bits of port_a
`define SHAMT_W 5

// R-type funct field
`define FUNCT_W 6

// Number of identical ALU lanes, 2 or more
// Dispatch and writeback rotate over the same count
`define ALU_LANES 4

`endif
